//--- itch_pkg.sv
package itch_pkg;

    //////////////////////////////////////////////////
    // Message type bytes
    //////////////////////////////////////////////////

    localparam logic [7:0] msg_a = 8'h41;  // Add order, no MPID
    localparam logic [7:0] msg_f = 8'h46;  // Add order with MPID
    localparam logic [7:0] msg_e = 8'h45;  // Order executed
    localparam logic [7:0] msg_c = 8'h43;  // Order executed with price
    localparam logic [7:0] msg_x = 8'h58;  // Order cancel
    localparam logic [7:0] msg_d = 8'h44;  // Order delete

    // One-hot style order codes, zero means no order
    typedef enum logic [3:0] {
        code_none    = 4'h0,
        code_add     = 4'h1,
        code_cancel  = 4'h2,
        code_execute = 4'h4,
        code_delete  = 4'h8
    } order_code_t;

    //////////////////////////////////////////////////
    // Field offsets within the message body
    //////////////////////////////////////////////////

    // Body offset 0 is the type byte
    localparam logic [7:0] off_order_ref   = 8'd15;  // 4 bytes, low half of the reference
    localparam logic [7:0] off_side        = 8'd19;  // 'B' or 'S', bit 0 set for sell
    localparam logic [7:0] off_shares_add  = 8'd20;  // A and F
    localparam logic [7:0] off_shares_exec = 8'd19;  // E, C and X
    localparam logic [7:0] off_stock       = 8'd24;  // First four symbol bytes
    localparam logic [7:0] off_price       = 8'd32;  // A, F and C

    //////////////////////////////////////////////////
    // Framer to extractor beat
    //////////////////////////////////////////////////

    typedef struct packed {
        logic [7:0] data;    // Body byte
        logic [7:0] offset;  // Position in the body
        logic       last;    // High on offset L-1
    } itch_beat_t;

    //////////////////////////////////////////////////
    // Order record
    //////////////////////////////////////////////////

    // All multi-byte fields are big endian on the wire
    typedef struct packed {
        order_code_t code;
        logic        sell;
        logic [31:0] order_ref;
        logic [31:0] shares;
        logic [31:0] stock;
        logic [31:0] price;
    } itch_order_t;

endpackage

//--- itch_framer.sv
module itch_framer
    import itch_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,

    // Byte stream from upstream
    input  logic [7:0] data_i,
    input  logic       valid_i,
    output logic       ready_o,

    // Output side is full for a kept message
    input  logic       hold_i,

    // Body beats to the extractor
    output logic       beat_valid_o,
    output itch_beat_t beat_o
);

    typedef enum logic {
        st_wait_len,  // Next byte is a length byte
        st_body       // Next byte is a body byte
    } framer_state_t;

    framer_state_t state_q;
    logic [7:0]    len_q;     // Body length of current message
    logic [7:0]    offset_q;  // Offset of next body byte
    logic          accept;
    logic          last_pending;

    //////////////////////////////////////////////////
    // Handshake
    //////////////////////////////////////////////////

    // Next body byte closes the message
    assign last_pending = (state_q == st_body) && (offset_q == len_q - 8'd1);

    // Only the closing byte of a message waits for room downstream
    assign ready_o = !(hold_i && last_pending);
    assign accept  = valid_i && ready_o;

    // Beats leave in the cycle of the accept
    assign beat_valid_o  = accept && (state_q == st_body);
    assign beat_o.data   = data_i;
    assign beat_o.offset = offset_q;
    assign beat_o.last   = last_pending;

    //////////////////////////////////////////////////
    // Length and offset tracking
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q  <= st_wait_len;
            len_q    <= 8'd0;
            offset_q <= 8'd0;
        end else if (accept) begin
            case (state_q)
                st_wait_len: begin
                    // Zero length bytes are swallowed
                    if (data_i != 8'd0) begin
                        len_q    <= data_i;
                        offset_q <= 8'd0;
                        state_q  <= st_body;
                    end
                end
                st_body: begin
                    if (last_pending) begin
                        state_q <= st_wait_len;
                    end else begin
                        offset_q <= offset_q + 8'd1;
                    end
                end
                default: state_q <= st_wait_len;
            endcase
        end
    end

    // The offset counter must stop at the stored length
    a_offset_in_body: assert property (
        @(posedge clk) disable iff (!reset_n)
        beat_valid_o |-> (beat_o.offset < len_q)
    );

endmodule

//--- itch_field_extract.sv
module itch_field_extract
    import itch_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,

    // Beats from the framer, never refused
    input  logic        beat_valid_i,
    input  itch_beat_t  beat_i,

    // Output slot status
    input  logic        slot_full_i,
    input  logic        ready_i,
    output logic        hold_o,

    // Finished orders
    output logic        push_o,
    output itch_order_t push_order_o
);

    itch_order_t rec_q;        // Record under assembly, code is the registered type
    itch_order_t rec_next;     // Record with the current byte applied
    logic        has_price_q;  // A, F and C carry a price
    order_code_t type_code;
    logic        type_has_price;

    // Place a byte into a 32-bit big endian field at base..base+3
    function automatic logic [31:0] put_byte(
        input logic [31:0] word,
        input logic [7:0]  base,
        input logic [7:0]  off,
        input logic [7:0]  data
    );
        logic [7:0]  idx;
        logic [31:0] res;
        idx = off - base;  // Wraps high when off is below base
        res = word;
        if (idx < 8'd4) begin
            res[{~idx[1:0], 3'b000} +: 8] = data;  // Byte 0 is the MSB
        end
        return res;
    endfunction

    //////////////////////////////////////////////////
    // Type decode
    //////////////////////////////////////////////////

    always_comb begin
        type_code      = code_none;
        type_has_price = 1'b0;
        case (beat_i.data)
            msg_a, msg_f: begin
                type_code      = code_add;
                type_has_price = 1'b1;
            end
            msg_e: type_code = code_execute;
            msg_c: begin
                type_code      = code_execute;
                type_has_price = 1'b1;
            end
            msg_x: type_code = code_cancel;
            msg_d: type_code = code_delete;
            default: ;  // Skipped type
        endcase
    end

    //////////////////////////////////////////////////
    // Field assembly
    //////////////////////////////////////////////////

    always_comb begin
        rec_next = rec_q;
        if (beat_i.offset != 8'd0) begin
            case (rec_q.code)
                code_add: begin
                    rec_next.order_ref = put_byte(rec_q.order_ref, off_order_ref,
                                                  beat_i.offset, beat_i.data);
                    if (beat_i.offset == off_side) begin
                        rec_next.sell = beat_i.data[0];  // 'S' has bit 0 set
                    end
                    rec_next.shares = put_byte(rec_q.shares, off_shares_add,
                                               beat_i.offset, beat_i.data);
                    rec_next.stock  = put_byte(rec_q.stock, off_stock,
                                               beat_i.offset, beat_i.data);
                end
                code_execute, code_cancel: begin
                    rec_next.order_ref = put_byte(rec_q.order_ref, off_order_ref,
                                                  beat_i.offset, beat_i.data);
                    rec_next.shares    = put_byte(rec_q.shares, off_shares_exec,
                                                  beat_i.offset, beat_i.data);
                end
                code_delete: begin
                    rec_next.order_ref = put_byte(rec_q.order_ref, off_order_ref,
                                                  beat_i.offset, beat_i.data);
                end
                default: ;
            endcase
            if (has_price_q) begin
                rec_next.price = put_byte(rec_q.price, off_price, beat_i.offset, beat_i.data);
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rec_q       <= '0;
            has_price_q <= 1'b0;
        end else if (beat_valid_i) begin
            if (beat_i.last) begin
                // Back to idle so hold drops between messages
                rec_q       <= '0;
                has_price_q <= 1'b0;
            end else if (beat_i.offset == 8'd0) begin
                rec_q       <= '0;
                rec_q.code  <= type_code;
                has_price_q <= type_has_price;
            end else begin
                rec_q <= rec_next;
            end
        end
    end

    // Last byte lands in the pushed record directly
    assign push_o       = beat_valid_i && beat_i.last && (beat_i.offset != 8'd0) &&
                          (rec_q.code != code_none);
    assign push_order_o = rec_next;

    // Kept message in progress with nowhere to put it
    assign hold_o = (rec_q.code != code_none) && slot_full_i && !ready_i;

    a_push_has_room: assert property (
        @(posedge clk) disable iff (!reset_n)
        push_o |-> (!slot_full_i || ready_i)
    );

endmodule

//--- itch_order_out.sv
module itch_order_out
    import itch_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,

    // From the extractor
    input  logic        push_i,
    input  itch_order_t push_order_i,
    output logic        slot_full_o,

    // Downstream order port
    output itch_order_t order_o,
    output logic        valid_o,
    input  logic        ready_i
);

    logic        full_q;
    itch_order_t order_q;
    logic        pop;

    //////////////////////////////////////////////////
    // Single entry slot
    //////////////////////////////////////////////////

    assign pop = full_q && ready_i;  // Transfer this cycle

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            full_q <= 1'b0;
        end else if (push_i) begin
            full_q <= 1'b1;  // Load, or reload behind a pop
        end else if (pop) begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            order_q <= '0;
        end else if (push_i) begin
            order_q <= push_order_i;
        end
    end

    assign slot_full_o = full_q;
    assign valid_o     = full_q;
    assign order_o     = order_q;

    // An offered order holds until taken
    a_order_stable: assert property (
        @(posedge clk) disable iff (!reset_n)
        (valid_o && !ready_i) |=> (valid_o && $stable(order_o))
    );

endmodule

//--- itch_parser_top.sv
module itch_parser_top
    import itch_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,

    // ITCH byte stream in
    input  logic [7:0]  data_i,
    input  logic        valid_i,
    output logic        ready_o,

    // Order records out
    output itch_order_t order_o,
    output logic        valid_o,
    input  logic        ready_i
);

    logic        beat_valid;
    itch_beat_t  beat;
    logic        hold;
    logic        push;
    itch_order_t push_order;
    logic        slot_full;

    itch_framer u_framer (
        .clk          (clk),
        .reset_n      (reset_n),
        .data_i       (data_i),
        .valid_i      (valid_i),
        .ready_o      (ready_o),
        .hold_i       (hold),
        .beat_valid_o (beat_valid),
        .beat_o       (beat)
    );

    itch_field_extract u_extract (
        .clk          (clk),
        .reset_n      (reset_n),
        .beat_valid_i (beat_valid),
        .beat_i       (beat),
        .slot_full_i  (slot_full),
        .ready_i      (ready_i),
        .hold_o       (hold),
        .push_o       (push),
        .push_order_o (push_order)
    );

    itch_order_out u_out (
        .clk          (clk),
        .reset_n      (reset_n),
        .push_i       (push),
        .push_order_i (push_order),
        .slot_full_o  (slot_full),
        .order_o      (order_o),
        .valid_o      (valid_o),
        .ready_i      (ready_i)
    );

endmodule

//--- tb_itch_tests.svh
//////////////////////////////////////////////////
// Directed tests
//////////////////////////////////////////////////

task automatic check_offered();
    assert (valid_o) else begin
        $display("valid_o not high one cycle after the last byte in %s", test_name);
        other_count++;
    end
endtask

task automatic test_add_orders();
    test_name = "add_orders";
    ready_i   = 1'b1;
    build_msg(msg_a, 36, 32'h0012_3456, 32'd100, 32'h4142_4344, 32'd1_500_000, 1'b0);
    send_msg();
    check_offered();
    build_msg(msg_f, 40, 32'hdead_beef, 32'd250, 32'h4d53_4654, 32'h0001_86a0, 1'b1);
    send_msg();
    check_offered();
    wait_drain(50);
endtask

task automatic test_other_types();
    test_name = "other_types";
    // Bodies run past the price so fields the type lacks have bytes to pick up
    build_msg(msg_e, 36, 32'h0000_0101, 32'h0100_004b, 32'd0, 32'd0, 1'b0);  // Odd top share byte
    send_msg();
    build_msg(msg_c, 36, 32'h0a0b_0c0d, 32'd10, 32'd0, 32'd123_400, 1'b0);
    send_msg();
    build_msg(msg_x, 36, 32'h1111_2222, 32'd5, 32'd0, 32'd0, 1'b0);
    send_msg();
    build_msg(msg_d, 36, 32'h7fff_fffe, 32'd0, 32'd0, 32'd0, 1'b0);
    send_msg();
    // Short add with the price and half the stock past L
    build_msg(msg_a, 26, 32'h0000_00aa, 32'd42, 32'h494e_5443, 32'd999, 1'b1);
    send_msg();
    wait_drain(50);
endtask

task automatic test_skipped_input();
    test_name = "skipped_input";
    build_msg(msg_a, 36, 32'h0000_0001, 32'd1, 32'h5858_5858, 32'd1, 1'b0);
    send_msg();
    build_msg(8'h5a, 20, 32'd0, 32'd0, 32'd0, 32'd0, 1'b0);  // Unknown type
    send_msg();
    send_byte(8'h00);  // Zero length bytes
    send_byte(8'h00);
    build_msg(msg_a, 1, 32'd0, 32'd0, 32'd0, 32'd0, 1'b0);    // Type byte only
    send_msg();
    build_msg(8'h50, 40, 32'd0, 32'd0, 32'd0, 32'd0, 1'b0);   // Trade message
    send_msg();
    build_msg(msg_d, 19, 32'h0000_0002, 32'd0, 32'd0, 32'd0, 1'b0);
    send_msg();
    wait_drain(50);
endtask

task automatic test_back_pressure();
    int i;
    test_name  = "back_pressure";
    ready_i    = 1'b0;
    stall_seen = 1'b0;
    build_msg(msg_a, 36, 32'h0000_0a0a, 32'd300, 32'h4141_5050, 32'd2_000_000, 1'b1);
    send_msg();
    assert (!stall_seen) else begin
        $display("ready_o fell while the output slot was empty");
        other_count++;
    end
    build_msg(msg_e, 31, 32'h0000_0b0b, 32'd120, 32'd0, 32'd0, 1'b0);
    fork
        send_msg();
        begin
            for (i = 0; i < 100 && !stall_seen; i++) begin
                @(negedge clk);
            end
            assert (stall_seen) else begin
                $display("ready_o did not fall before the last byte of the second message");
                other_count++;
            end
            assert (valid_o) else begin
                $display("no order offered while the output was stalled");
                other_count++;
            end
            repeat (3) @(negedge clk);
            ready_i = 1'b1;  // Release both orders
        end
    join
    wait_drain(50);
    assert (ready_o) else begin
        $display("ready_o still low after the back-pressure cleared");
        other_count++;
    end
endtask

function automatic int std_len(input logic [7:0] t);
    case (t)
        msg_a, msg_c: return 36;
        msg_f:        return 40;
        msg_e:        return 31;
        msg_x:        return 23;
        msg_d:        return 19;
        default:      return 20;
    endcase
endfunction

task automatic test_random_stream();
    int          n;
    int          len;
    logic [31:0] r;
    logic [7:0]  t;
    test_name   = "random_stream";
    gaps_on     = 1'b1;
    stream_busy = 1'b1;
    fork
        begin
            for (n = 0; n < n_random_msgs; n++) begin
                r = next_rand();
                case (r[18:16])
                    3'd0: t = msg_a;
                    3'd1: t = msg_f;
                    3'd2: t = msg_e;
                    3'd3: t = msg_c;
                    3'd4: t = msg_x;
                    3'd5: t = msg_d;
                    3'd6: t = 8'h5a;
                    default: t = 8'h50;
                endcase
                len = std_len(t);
                if (r[3:0] == 4'd0) begin
                    len = 1 + int'(next_rand() >> 27);  // Irregular length from 1 to 32
                end
                build_msg(t, len, next_rand(), next_rand(), next_rand(), next_rand(), r[20]);
                send_msg();
            end
            stream_busy = 1'b0;
        end
        begin
            while (stream_busy) begin
                @(negedge clk);
                ready_state = lcg_next(ready_state);
                ready_i     = (ready_state[31:30] != 2'b00);  // Stall a quarter of cycles
            end
        end
    join
    ready_i = 1'b1;
    gaps_on = 1'b0;
    wait_drain(100);
endtask

//--- tb_itch_parser.sv
module tb_itch_parser
    import itch_pkg::*;
();

    //////////////////////////////////////////////////
    // Run length and watchdog
    //////////////////////////////////////////////////

    localparam int n_random_msgs  = 40;
    localparam int max_msg_bytes  = 41;  // Length byte plus the longest body
    localparam int directed_bytes = 600;
    localparam int margin_bytes   = 200;
    localparam int slack          = 5;
    // Random bytes can each see up to three idle cycles
    localparam int watchdog_time  =
        (directed_bytes + n_random_msgs * max_msg_bytes * 4 + margin_bytes) * 100 * slack;

    logic        clk = 1'b0;
    logic        reset_n;
    logic [7:0]  data_i;
    logic        valid_i;
    logic        ready_o;
    itch_order_t order_o;
    logic        valid_o;
    logic        ready_i;

    logic [7:0]  body[$];      // Body of the message being built
    itch_order_t exp_q[$];     // Orders expected at the output, oldest first
    string       test_name;
    int          mismatch_count;
    int          other_count;
    logic [31:0] rnd_state;
    logic [31:0] ready_state;
    logic        gaps_on;      // Idle cycles between input bytes
    logic        stall_seen;   // ready_o was low with a byte offered
    logic        stream_busy;

    itch_parser_top u_itch_parser_top (
        .clk     (clk),
        .reset_n (reset_n),
        .data_i  (data_i),
        .valid_i (valid_i),
        .ready_o (ready_o),
        .order_o (order_o),
        .valid_o (valid_o),
        .ready_i (ready_i)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] next_rand();
        rnd_state = lcg_next(rnd_state);
        return rnd_state;
    endfunction

    //////////////////////////////////////////////////
    // Input side
    //////////////////////////////////////////////////

    // Starts and ends on a falling edge
    task automatic send_byte(input logic [7:0] b);
        data_i  = b;
        valid_i = 1'b1;
        @(posedge clk);
        while (!ready_o) begin
            stall_seen = 1'b1;
            @(posedge clk);
        end
        @(negedge clk);
        valid_i = 1'b0;
    endtask

    task automatic take_gap();
        if (gaps_on) begin
            repeat (int'(next_rand() >> 30)) @(negedge clk);
        end
    endtask

    // Big endian field, bytes past the body end are dropped
    task automatic put_field(input logic [7:0] off, input logic [31:0] value);
        int k;
        int pos;
        for (k = 0; k < 4; k++) begin
            pos = int'(off) + k;
            if (pos < body.size()) begin
                body[pos] = 8'(value >> (24 - 8 * k));
            end
        end
    endtask

    task automatic build_msg(input logic [7:0] mtype, input int len, input logic [31:0] ref_v,
                             input logic [31:0] shares, input logic [31:0] stock,
                             input logic [31:0] price, input logic sell);
        int i;
        body.delete();
        for (i = 0; i < len; i++) begin
            body.push_back(8'(i * 37 + 11));  // Filler
        end
        if (len > 0) begin
            body[0] = mtype;
        end
        case (mtype)
            msg_a, msg_f: begin
                put_field(off_order_ref, ref_v);
                if (int'(off_side) < body.size()) begin
                    body[off_side] = sell ? 8'h53 : 8'h42;  // 'S' or 'B'
                end
                put_field(off_shares_add, shares);
                put_field(off_stock, stock);
                put_field(off_price, price);
            end
            msg_e, msg_x: begin
                put_field(off_order_ref, ref_v);
                put_field(off_shares_exec, shares);
            end
            msg_c: begin
                put_field(off_order_ref, ref_v);
                put_field(off_shares_exec, shares);
                put_field(off_price, price);
            end
            msg_d: put_field(off_order_ref, ref_v);
            default: ;
        endcase
    endtask

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    function automatic logic [31:0] field_at(input logic [7:0] off);
        logic [31:0] w;
        int          k;
        int          pos;
        w = '0;
        for (k = 0; k < 4; k++) begin
            pos = int'(off) + k;
            w   = {w[23:0], (pos < body.size()) ? body[pos] : 8'h00};  // Zero past L
        end
        return w;
    endfunction

    function automatic itch_order_t expected_order();
        itch_order_t e;
        logic [7:0]  side;
        e = '0;
        case (body[0])
            msg_a, msg_f: begin
                e.code = code_add;
                if (int'(off_side) < body.size()) begin
                    side   = body[off_side];
                    e.sell = side[0];
                end
                e.order_ref = field_at(off_order_ref);
                e.shares    = field_at(off_shares_add);
                e.stock     = field_at(off_stock);
                e.price     = field_at(off_price);
            end
            msg_e, msg_c: begin
                e.code      = code_execute;
                e.order_ref = field_at(off_order_ref);
                e.shares    = field_at(off_shares_exec);
                if (body[0] == msg_c) e.price = field_at(off_price);
            end
            msg_x: begin
                e.code      = code_cancel;
                e.order_ref = field_at(off_order_ref);
                e.shares    = field_at(off_shares_exec);
            end
            msg_d: begin
                e.code      = code_delete;
                e.order_ref = field_at(off_order_ref);
            end
            default: e.code = code_none;  // Skipped type
        endcase
        return e;
    endfunction

    task automatic send_msg();
        itch_order_t e;
        int          i;
        e = expected_order();
        if (e.code != code_none && body.size() >= 2) begin
            exp_q.push_back(e);
        end
        send_byte(8'(body.size()));
        take_gap();
        for (i = 0; i < body.size(); i++) begin
            send_byte(body[i]);
            take_gap();
        end
    endtask

    task automatic wait_drain(input int max_cycles);
        int n;
        n = 0;
        while ((exp_q.size() != 0 || valid_o) && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        assert (exp_q.size() == 0 && !valid_o) else begin
            $display("%0d orders missing at the end of %s", exp_q.size(), test_name);
            other_count++;
            exp_q.delete();
        end
    endtask

    // Output transfers, checked in order
    always @(posedge clk) begin : check_outputs
        itch_order_t exp_o;
        if (reset_n && valid_o && ready_i) begin
            assert (exp_q.size() != 0) else begin
                $display("unexpected order in %s: %h", test_name, order_o);
                other_count++;
            end
            if (exp_q.size() != 0) begin
                exp_o = exp_q.pop_front();
                assert (order_o == exp_o) else begin
                    $display("mismatch in %s: expected %h, actual %h",
                             test_name, exp_o, order_o);
                    mismatch_count++;
                end
            end
        end
    end

    `include "tb_itch_tests.svh"

    initial begin : watchdog
        #(watchdog_time);
        $display("Timeout: the tests did not finish in %0d time units", watchdog_time);
        $display("Something failed");
        $finish;
    end

    initial begin
        reset_n        = 1'b0;
        data_i         = 8'h00;
        valid_i        = 1'b0;
        ready_i        = 1'b1;
        mismatch_count = 0;
        other_count    = 0;
        rnd_state      = 32'heb022b31;
        ready_state    = lcg_next(32'heb022b31 ^ 32'h5a5a_5a5a);
        gaps_on        = 1'b0;
        stall_seen     = 1'b0;
        stream_busy    = 1'b0;
        test_name      = "reset";
        repeat (4) @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);
        assert (!valid_o && ready_o) else begin
            $display("parser not idle after reset");
            other_count++;
        end
        test_add_orders();
        test_other_types();
        test_skipped_input();
        test_back_pressure();
        test_random_stream();
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count + other_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+.
itch_pkg.sv
itch_framer.sv
itch_field_extract.sv
itch_order_out.sv
itch_parser_top.sv
tb_itch_parser.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the ITCH parser testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_itch_parser -o tb_sim

if ./obj_dir/tb_sim | tee /dev/stderr | grep -x "Everything OK" > /dev/null; then
    exit 0
fi
exit 1
